/* design/cfg_regs.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module cfg_regs (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            cfg_write,
    input  logic [`MEMOREDF_CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`MEMOREDF_CFG_W-1:0]      cfg_wdata,
    sched_cfg_if.source                     cfg
);

    localparam int NQ     = `MEMOREDF_NUM_QUEUES;
    localparam int PRIO_W = `MEMOREDF_PRIO_W;
    localparam int THR_W  = `MEMOREDF_THR_W;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cfg.mode <= `MEMOREDF_MODE_RESET;
            for (int q = 0; q < NQ; q++)
            begin
                // Queue q starts with priority q
                cfg.prio[q]      <= PRIO_W'(q);
                cfg.deadline[q]  <= `MEMOREDF_DL_RESET;
                cfg.threshold[q] <= `MEMOREDF_THR_RESET;
            end
        end
        else if (cfg_write)
        begin
            case (cfg_addr)
                4'd0: cfg.mode <= cfg_wdata[0];
                4'd1:
                begin
                    for (int q = 0; q < NQ; q++)
                        cfg.prio[q] <= cfg_wdata[PRIO_W*q +: PRIO_W];
                end
                // One deadline per address, queue 0 at address 2
                4'd2, 4'd3, 4'd4, 4'd5:
                    cfg.deadline[cfg_addr[1:0] - 2'd2] <= cfg_wdata[`MEMOREDF_DL_W-1:0];
                4'd6:
                begin
                    for (int q = 0; q < NQ; q++)
                        cfg.threshold[q] <= cfg_wdata[THR_W*q +: THR_W];
                end
                default: ;
            endcase
        end
    end

    a_addr_known: assert property (@(posedge aclk) disable iff (!rst_n)
        cfg_write |-> !$isunknown(cfg_addr));

endmodule

/* design/deadline_scheduler.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module deadline_scheduler (
    input  logic                                    aclk,
    input  logic                                    rst_n,
    sched_cfg_if.sink                               cfg,
    input  logic [`MEMOREDF_NUM_QUEUES-1:0]         nonempty,
    input  logic                                    ready,
    output logic                                    pop,
    output logic [$clog2(`MEMOREDF_NUM_QUEUES)-1:0] pop_sel
);

    localparam int NQ     = `MEMOREDF_NUM_QUEUES;
    localparam int QSEL_W = $clog2(NQ);
    localparam int DL_W   = `MEMOREDF_DL_W;

    logic [DL_W-1:0] counter [NQ];
    logic [DL_W-1:0] current [NQ];
    logic [DL_W-1:0] key [NQ];
    logic [NQ-1:0]   seen;
    logic [NQ-1:0]   fresh;
    logic [NQ-1:0]   popped;
    logic [DL_W-1:0] best_key;
    logic            found;

    // A head is new when the queue was empty or was popped last cycle
    assign fresh = nonempty & ~seen;

    always_comb
    begin
        for (int q = 0; q < NQ; q++)
        begin
            current[q] = fresh[q] ? cfg.deadline[q] : counter[q];
            key[q]     = cfg.mode ? current[q] : DL_W'(cfg.prio[q]);
        end
    end

    always_comb
    begin
        for (int q = 0; q < NQ; q++)
            popped[q] = pop && pop_sel == QSEL_W'(q);
    end

    // Smallest key wins, strict compare keeps ties on the lower index
    always_comb
    begin
        found    = 1'b0;
        pop_sel  = '0;
        best_key = '1;
        for (int q = 0; q < NQ; q++)
        begin
            if (nonempty[q] && (!found || key[q] < best_key))
            begin
                found    = 1'b1;
                pop_sel  = QSEL_W'(q);
                best_key = key[q];
            end
        end
    end

    assign pop = ready && found;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            seen <= '0;
            for (int q = 0; q < NQ; q++)
                counter[q] <= '0;
        end
        else
        begin
            seen <= nonempty & ~popped;
            // Count down and saturate at zero
            for (int q = 0; q < NQ; q++)
                counter[q] <= (current[q] == '0) ? '0 : current[q] - 1'b1;
        end
    end

    a_pick_nonempty: assert property (@(posedge aclk) disable iff (!rst_n)
        pop |-> nonempty[pop_sel]);

endmodule

/* design/memoredf_pkg.sv */
`include "memoredf_config.svh"

package memoredf_pkg;

    // One ID word, seen raw on the memory side or split into port tag and local ID
    typedef union packed {
        logic [`MEMOREDF_ID_W-1:0] raw;
        struct packed {
            logic                      src;
            logic [`MEMOREDF_ID_W-2:0] sub_id;
        } view;
    } txn_id_u;

endpackage

/* design/memoredf_top.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module memoredf_top (
    input  logic                            aclk,
    input  logic                            rst_n,
    input  logic                            s0_valid,
    output logic                            s0_ready,
    input  logic [`MEMOREDF_ADDR_W-1:0]     s0_addr,
    input  logic [`MEMOREDF_ID_W-2:0]       s0_id,
    input  logic                            s0_write,
    input  logic [`MEMOREDF_DATA_W-1:0]     s0_wdata,
    input  logic                            s1_valid,
    output logic                            s1_ready,
    input  logic [`MEMOREDF_ADDR_W-1:0]     s1_addr,
    input  logic [`MEMOREDF_ID_W-2:0]       s1_id,
    input  logic                            s1_write,
    input  logic [`MEMOREDF_DATA_W-1:0]     s1_wdata,
    output logic                            m_req_valid,
    input  logic                            m_req_ready,
    output logic [`MEMOREDF_ADDR_W-1:0]     m_req_addr,
    output logic [`MEMOREDF_ID_W-1:0]       m_req_id,
    output logic                            m_req_write,
    output logic [`MEMOREDF_DATA_W-1:0]     m_req_wdata,
    input  logic                            m_rsp_valid,
    output logic                            m_rsp_ready,
    input  logic [`MEMOREDF_ID_W-1:0]       m_rsp_id,
    input  logic [`MEMOREDF_DATA_W-1:0]     m_rsp_rdata,
    output logic                            s0_rsp_valid,
    input  logic                            s0_rsp_ready,
    output logic [`MEMOREDF_ID_W-2:0]       s0_rsp_id,
    output logic [`MEMOREDF_DATA_W-1:0]     s0_rsp_rdata,
    output logic                            s1_rsp_valid,
    input  logic                            s1_rsp_ready,
    output logic [`MEMOREDF_ID_W-2:0]       s1_rsp_id,
    output logic [`MEMOREDF_DATA_W-1:0]     s1_rsp_rdata,
    input  logic                            cfg_write,
    input  logic [`MEMOREDF_CFG_ADDR_W-1:0] cfg_addr,
    input  logic [`MEMOREDF_CFG_W-1:0]      cfg_wdata,
    output logic [`MEMOREDF_NUM_QUEUES-1:0] kill_core
);

    logic [`MEMOREDF_NUM_QUEUES-1:0]         nonempty;
    logic                                    pop;
    logic [$clog2(`MEMOREDF_NUM_QUEUES)-1:0] pop_sel;
    logic                                    sched_ready;

    req_if       pkt0 ();
    req_if       pkt1 ();
    req_if       grant ();
    sched_cfg_if cfg ();

    cfg_regs u_cfg_regs (
        .aclk, .rst_n, .cfg_write, .cfg_addr, .cfg_wdata,
        .cfg (cfg.source)
    );

    ////////////////////////////////////////////////////////////
    // Request path
    request_packetizer #(.PORT_INDEX(0)) u_pkt0 (
        .aclk, .rst_n,
        .valid (s0_valid), .ready (s0_ready), .addr (s0_addr),
        .id (s0_id), .write (s0_write), .wdata (s0_wdata),
        .out (pkt0.producer)
    );

    request_packetizer #(.PORT_INDEX(1)) u_pkt1 (
        .aclk, .rst_n,
        .valid (s1_valid), .ready (s1_ready), .addr (s1_addr),
        .id (s1_id), .write (s1_write), .wdata (s1_wdata),
        .out (pkt1.producer)
    );

    queue_bank u_queue_bank (
        .aclk, .rst_n,
        .in0 (pkt0.consumer), .in1 (pkt1.consumer), .out (grant.producer),
        .cfg (cfg.sink), .pop, .pop_sel, .nonempty, .kill_core
    );

    deadline_scheduler u_scheduler (
        .aclk, .rst_n, .cfg (cfg.sink),
        .nonempty, .ready (sched_ready), .pop, .pop_sel
    );

    request_serializer u_serializer (
        .aclk, .rst_n, .in (grant.consumer), .ready_out (sched_ready),
        .m_req_valid, .m_req_ready, .m_req_addr, .m_req_id,
        .m_req_write, .m_req_wdata
    );

    ////////////////////////////////////////////////////////////
    // Response path
    response_router u_router (
        .m_rsp_valid, .m_rsp_ready, .m_rsp_id, .m_rsp_rdata,
        .s0_rsp_valid, .s0_rsp_ready, .s0_rsp_id, .s0_rsp_rdata,
        .s1_rsp_valid, .s1_rsp_ready, .s1_rsp_id, .s1_rsp_rdata
    );

endmodule

/* design/queue_bank.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module queue_bank (
    input  logic                                    aclk,
    input  logic                                    rst_n,
    req_if.consumer                                 in0,
    req_if.consumer                                 in1,
    req_if.producer                                 out,
    sched_cfg_if.sink                               cfg,
    input  logic                                    pop,
    input  logic [$clog2(`MEMOREDF_NUM_QUEUES)-1:0] pop_sel,
    output logic [`MEMOREDF_NUM_QUEUES-1:0]         nonempty,
    output logic [`MEMOREDF_NUM_QUEUES-1:0]         kill_core
);

    localparam int NQ      = `MEMOREDF_NUM_QUEUES;
    localparam int DEPTH   = `MEMOREDF_QUEUE_DEPTH;
    localparam int QSEL_W  = $clog2(NQ);
    localparam int PTR_W   = $clog2(DEPTH);
    localparam int CNT_W   = PTR_W + 1;
    localparam int ENTRY_W = `MEMOREDF_ADDR_W + `MEMOREDF_ID_W + 1 + `MEMOREDF_DATA_W;

    logic [NQ-1:0]      full;
    logic [ENTRY_W-1:0] head [NQ];
    logic               taken;

    // Port 0 wins when both ports target the same queue
    assign in0.ready = !full[in0.qsel];
    assign in1.ready = !full[in1.qsel] && !(in0.valid && in0.qsel == in1.qsel);

    ////////////////////////////////////////////////////////////
    // Per-core FIFOs
    for (genvar q = 0; q < NQ; q++)
    begin : g_queue
        logic [ENTRY_W-1:0] mem [DEPTH];
        logic [PTR_W-1:0]   wr_ptr;
        logic [PTR_W-1:0]   rd_ptr;
        logic [CNT_W-1:0]   count;
        logic               push0;
        logic               push1;
        logic               pull;

        assign push0 = in0.valid && in0.ready && in0.qsel == QSEL_W'(q);
        assign push1 = in1.valid && in1.ready && in1.qsel == QSEL_W'(q);
        assign pull  = taken && pop_sel == QSEL_W'(q);

        always_ff @(posedge aclk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end
            else
            begin
                if (push0 || push1)
                    wr_ptr <= wr_ptr + 1'b1;
                if (pull)
                    rd_ptr <= rd_ptr + 1'b1;
                count <= count + CNT_W'(push0 || push1) - CNT_W'(pull);
            end
        end

        always_ff @(posedge aclk)
        begin
            if (push0)
                mem[wr_ptr] <= {in0.addr, in0.id.raw, in0.write, in0.wdata};
            else if (push1)
                mem[wr_ptr] <= {in1.addr, in1.id.raw, in1.write, in1.wdata};
        end

        assign head[q]      = mem[rd_ptr];
        assign full[q]      = count == CNT_W'(DEPTH);
        assign nonempty[q]  = count != '0;
        // Alarm stays up while occupancy is at or above the threshold
        assign kill_core[q] = count >= cfg.threshold[q];

        a_no_overflow: assert property (@(posedge aclk) disable iff (!rst_n)
            (push0 || push1) |-> count < CNT_W'(DEPTH));
        a_no_underflow: assert property (@(posedge aclk) disable iff (!rst_n)
            pull |-> count != '0);
    end

    ////////////////////////////////////////////////////////////
    // Grant output, head of the selected queue
    assign taken     = out.valid && out.ready;
    assign out.valid = pop;
    assign out.qsel  = pop_sel;
    assign {out.addr, out.id, out.write, out.wdata} = head[pop_sel];

endmodule

/* design/req_if.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

interface req_if;
    import memoredf_pkg::*;

    logic                                    valid;
    logic                                    ready;
    logic [`MEMOREDF_ADDR_W-1:0]             addr;
    txn_id_u                                 id;
    logic                                    write;
    logic [`MEMOREDF_DATA_W-1:0]             wdata;
    logic [$clog2(`MEMOREDF_NUM_QUEUES)-1:0] qsel;

    modport producer (
        output valid, addr, id, write, wdata, qsel,
        input  ready
    );

    modport consumer (
        input  valid, addr, id, write, wdata, qsel,
        output ready
    );

endinterface

/* design/request_packetizer.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module request_packetizer #(
    parameter int PORT_INDEX = 0
) (
    input  logic                         aclk,
    input  logic                         rst_n,
    input  logic                         valid,
    output logic                         ready,
    input  logic [`MEMOREDF_ADDR_W-1:0]  addr,
    input  logic [`MEMOREDF_ID_W-2:0]    id,
    input  logic                         write,
    input  logic [`MEMOREDF_DATA_W-1:0]  wdata,
    req_if.producer                      out
);
    import memoredf_pkg::*;

    localparam int QSEL_W = $clog2(`MEMOREDF_NUM_QUEUES);

    txn_id_u tagged_id;

    // Top ID bit names the port the request came from
    always_comb
    begin
        tagged_id.view.src    = 1'(PORT_INDEX);
        tagged_id.view.sub_id = id;
    end

    // Free when empty or when the held request leaves this cycle
    assign ready = !out.valid || out.ready;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
            out.valid <= 1'b0;
        else if (ready)
            out.valid <= valid;
    end

    always_ff @(posedge aclk)
    begin
        if (valid && ready)
        begin
            out.addr  <= addr;
            out.id    <= tagged_id;
            out.write <= write;
            out.wdata <= wdata;
            out.qsel  <= addr[`MEMOREDF_QSEL_LSB +: QSEL_W];
        end
    end

    a_hold_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        out.valid && !out.ready |=> out.valid
            && $stable({out.addr, out.id.raw, out.write, out.wdata, out.qsel}));

endmodule

/* design/request_serializer.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module request_serializer (
    input  logic                         aclk,
    input  logic                         rst_n,
    req_if.consumer                      in,
    output logic                         ready_out,
    output logic                         m_req_valid,
    input  logic                         m_req_ready,
    output logic [`MEMOREDF_ADDR_W-1:0]  m_req_addr,
    output logic [`MEMOREDF_ID_W-1:0]    m_req_id,
    output logic                         m_req_write,
    output logic [`MEMOREDF_DATA_W-1:0]  m_req_wdata
);

    // Take a grant when empty or draining this cycle
    assign ready_out = !m_req_valid || m_req_ready;
    assign in.ready  = ready_out;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
            m_req_valid <= 1'b0;
        else if (ready_out)
            m_req_valid <= in.valid;
    end

    always_ff @(posedge aclk)
    begin
        if (in.valid && ready_out)
        begin
            m_req_addr  <= in.addr;
            m_req_id    <= in.id.raw;
            m_req_write <= in.write;
            m_req_wdata <= in.wdata;
        end
    end

    a_req_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        m_req_valid && !m_req_ready |=> m_req_valid
            && $stable({m_req_addr, m_req_id, m_req_write, m_req_wdata}));

endmodule

/* design/response_router.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module response_router (
    input  logic                         m_rsp_valid,
    output logic                         m_rsp_ready,
    input  logic [`MEMOREDF_ID_W-1:0]    m_rsp_id,
    input  logic [`MEMOREDF_DATA_W-1:0]  m_rsp_rdata,
    output logic                         s0_rsp_valid,
    input  logic                         s0_rsp_ready,
    output logic [`MEMOREDF_ID_W-2:0]    s0_rsp_id,
    output logic [`MEMOREDF_DATA_W-1:0]  s0_rsp_rdata,
    output logic                         s1_rsp_valid,
    input  logic                         s1_rsp_ready,
    output logic [`MEMOREDF_ID_W-2:0]    s1_rsp_id,
    output logic [`MEMOREDF_DATA_W-1:0]  s1_rsp_rdata
);
    import memoredf_pkg::*;

    txn_id_u rsp_id;

    assign rsp_id.raw = m_rsp_id;

    // The port not addressed by the tag sees all zeros
    always_comb
    begin
        s0_rsp_valid = 1'b0;
        s0_rsp_id    = '0;
        s0_rsp_rdata = '0;
        s1_rsp_valid = 1'b0;
        s1_rsp_id    = '0;
        s1_rsp_rdata = '0;
        if (rsp_id.view.src)
        begin
            s1_rsp_valid = m_rsp_valid;
            s1_rsp_id    = rsp_id.view.sub_id;
            s1_rsp_rdata = m_rsp_rdata;
            m_rsp_ready  = s1_rsp_ready;
        end
        else
        begin
            s0_rsp_valid = m_rsp_valid;
            s0_rsp_id    = rsp_id.view.sub_id;
            s0_rsp_rdata = m_rsp_rdata;
            m_rsp_ready  = s0_rsp_ready;
        end
    end

endmodule

/* design/sched_cfg_if.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

interface sched_cfg_if;

    // 0 selects fixed priority, 1 selects EDF
    logic                                                   mode;
    logic [`MEMOREDF_NUM_QUEUES-1:0][`MEMOREDF_PRIO_W-1:0]  prio;
    logic [`MEMOREDF_NUM_QUEUES-1:0][`MEMOREDF_DL_W-1:0]    deadline;
    logic [`MEMOREDF_NUM_QUEUES-1:0][`MEMOREDF_THR_W-1:0]   threshold;

    modport source (
        output mode, prio, deadline, threshold
    );

    modport sink (
        input  mode, prio, deadline, threshold
    );

endinterface

/* include/memoredf_config.svh */
`ifndef MEMOREDF_CONFIG_SVH
`define MEMOREDF_CONFIG_SVH

// Queue geometry
`define MEMOREDF_NUM_QUEUES  4
`define MEMOREDF_QUEUE_DEPTH 4

// Request and response fields
`define MEMOREDF_ADDR_W      16
`define MEMOREDF_DATA_W      32
`define MEMOREDF_ID_W        4
`define MEMOREDF_QSEL_LSB    14

// Scheduler configuration
`define MEMOREDF_PRIO_W      4
`define MEMOREDF_DL_W        16
`define MEMOREDF_THR_W       3
`define MEMOREDF_CFG_ADDR_W  4
`define MEMOREDF_CFG_W       32

// Reset values of the configuration registers
`define MEMOREDF_MODE_RESET  1'b0
`define MEMOREDF_DL_RESET    16'hffff
`define MEMOREDF_THR_RESET   3'd4

`endif

/* memoredf.f */
+incdir+include
design/memoredf_pkg.sv
design/req_if.sv
design/sched_cfg_if.sv
design/cfg_regs.sv
design/request_packetizer.sv
design/queue_bank.sv
design/deadline_scheduler.sv
design/request_serializer.sv
design/response_router.sv
design/memoredf_top.sv
tb/memoredf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f memoredf.f --top-module memoredf_tb \
    -o memoredf_sim

output=$(./obj_dir/memoredf_sim)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

/* tb/memoredf_tb.sv */
`timescale 1ns/1ns
`include "memoredf_config.svh"

module clock_gen (
    output logic aclk,
    output logic rst_n
);

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Reset spans the first two rising edges
    initial
    begin
        rst_n = 1'b0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
    end

endmodule

module memoredf_tb;
    import memoredf_pkg::*;

    localparam int ADDR_W = `MEMOREDF_ADDR_W;
    localparam int DATA_W = `MEMOREDF_DATA_W;
    localparam int SUB_W  = `MEMOREDF_ID_W - 1;
    localparam int NQ     = `MEMOREDF_NUM_QUEUES;
    // About ten times the cycles that all tests need
    localparam int MAX_CYCLES = 2000;

    logic                            aclk;
    logic                            rst_n;
    logic                            s0_valid;
    logic                            s0_ready;
    logic [ADDR_W-1:0]               s0_addr;
    logic [SUB_W-1:0]                s0_id;
    logic                            s0_write;
    logic [DATA_W-1:0]               s0_wdata;
    logic                            s1_valid;
    logic                            s1_ready;
    logic [ADDR_W-1:0]               s1_addr;
    logic [SUB_W-1:0]                s1_id;
    logic                            s1_write;
    logic [DATA_W-1:0]               s1_wdata;
    logic                            m_req_valid;
    logic                            m_req_ready;
    logic [ADDR_W-1:0]               m_req_addr;
    logic [`MEMOREDF_ID_W-1:0]       m_req_id;
    logic                            m_req_write;
    logic [DATA_W-1:0]               m_req_wdata;
    logic                            m_rsp_valid;
    logic                            m_rsp_ready;
    logic [`MEMOREDF_ID_W-1:0]       m_rsp_id;
    logic [DATA_W-1:0]               m_rsp_rdata;
    logic                            s0_rsp_valid;
    logic                            s0_rsp_ready;
    logic [SUB_W-1:0]                s0_rsp_id;
    logic [DATA_W-1:0]               s0_rsp_rdata;
    logic                            s1_rsp_valid;
    logic                            s1_rsp_ready;
    logic [SUB_W-1:0]                s1_rsp_id;
    logic [DATA_W-1:0]               s1_rsp_rdata;
    logic                            cfg_write;
    logic [`MEMOREDF_CFG_ADDR_W-1:0] cfg_addr;
    logic [`MEMOREDF_CFG_W-1:0]      cfg_wdata;
    logic [NQ-1:0]                   kill_core;

    // Expected contents of each request in flight
    txn_id_u           sent_id    [4];
    logic [ADDR_W-1:0] sent_addr  [4];
    logic [DATA_W-1:0] sent_data  [4];
    logic              sent_write [4];

    int     errors;
    int     cycles;
    integer seed;

    clock_gen u_clock (.aclk, .rst_n);

    memoredf_top dut (.*);

    ////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic check_bits(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_rsp(input string what, input logic [SUB_W-1:0] got_id,
            input logic [DATA_W-1:0] got_data, input logic [SUB_W-1:0] exp_id,
            input logic [DATA_W-1:0] exp_data);
        if (got_id !== exp_id || got_data !== exp_data)
        begin
            errors++;
            $display("Error at %0t: %s id %0d data %h, expected id %0d data %h",
                $time, what, got_id, got_data, exp_id, exp_data);
        end
    endtask

    task automatic check_req(input txn_id_u got_id, input logic [ADDR_W-1:0] got_addr,
            input logic [DATA_W-1:0] got_data, input logic got_write,
            input txn_id_u exp_id, input logic [ADDR_W-1:0] exp_addr,
            input logic [DATA_W-1:0] exp_data, input logic exp_write);
        if (got_id.raw !== exp_id.raw || got_addr !== exp_addr
            || got_data !== exp_data || got_write !== exp_write)
        begin
            errors++;
            $display("Error at %0t: m_req src %0d sub_id %0d addr %h data %h write %b",
                $time, got_id.view.src, got_id.view.sub_id, got_addr, got_data, got_write);
            $display("    expected src %0d sub_id %0d addr %h data %h write %b",
                exp_id.view.src, exp_id.view.sub_id, exp_addr, exp_data, exp_write);
        end
    endtask

    task automatic expect_kill(input logic [NQ-1:0] exp);
        for (int q = 0; q < NQ; q++)
            check_bits($sformatf("kill_core[%0d]", q), kill_core[q], exp[q]);
    endtask

    ////////////////////////////////////////////////////////////
    // Drivers called on a falling edge
    function automatic logic [ADDR_W-1:0] make_addr(input logic [1:0] q,
            input logic [31:0] r);
        return {q, r[`MEMOREDF_QSEL_LSB-1:0]};
    endfunction

    task automatic write_cfg(input logic [`MEMOREDF_CFG_ADDR_W-1:0] addr,
            input logic [`MEMOREDF_CFG_W-1:0] data);
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge aclk);
        cfg_write = 1'b0;
    endtask

    task automatic send_req(input logic [1:0] slot, input logic port, input logic [1:0] q,
            input logic wr);
        txn_id_u     tid;
        logic [31:0] r;
        r = $random(seed);
        tid.view.src     = port;
        tid.view.sub_id  = r[SUB_W-1:0];
        sent_id[slot]    = tid;
        sent_addr[slot]  = make_addr(q, $random(seed));
        sent_data[slot]  = $random(seed);
        sent_write[slot] = wr;
        if (port)
        begin
            s1_valid = 1'b1;
            s1_addr  = sent_addr[slot];
            s1_id    = tid.view.sub_id;
            s1_write = wr;
            s1_wdata = sent_data[slot];
        end
        else
        begin
            s0_valid = 1'b1;
            s0_addr  = sent_addr[slot];
            s0_id    = tid.view.sub_id;
            s0_write = wr;
            s0_wdata = sent_data[slot];
        end
        // Taken on the next rising edge once ready is seen high
        while (!(port ? s1_ready : s0_ready))
            @(negedge aclk);
        @(negedge aclk);
        if (port)
            s1_valid = 1'b0;
        else
            s0_valid = 1'b0;
    endtask

    task automatic wait_req(input logic [1:0] slot);
        txn_id_u got;
        while (!m_req_valid)
            @(negedge aclk);
        got.raw = m_req_id;
        check_req(got, m_req_addr, m_req_wdata, m_req_write,
            sent_id[slot], sent_addr[slot], sent_data[slot], sent_write[slot]);
        // Leaves on the next rising edge while m_req_ready is high
        @(negedge aclk);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    task automatic reset_state();
        check_bits("m_req_valid after reset", m_req_valid, 1'b0);
        check_bits("s0_rsp_valid after reset", s0_rsp_valid, 1'b0);
        check_bits("s1_rsp_valid after reset", s1_rsp_valid, 1'b0);
        check_bits("s0_ready after reset", s0_ready, 1'b1);
        check_bits("s1_ready after reset", s1_ready, 1'b1);
        expect_kill('0);
    endtask

    task automatic tag_requests();
        send_req(2'd0, 1'b0, 2'd0, 1'b1);
        // Queue write one edge after the handshake and serializer load one edge later
        @(negedge aclk);
        check_bits("m_req_valid one cycle after handshake", m_req_valid, 1'b0);
        @(negedge aclk);
        check_bits("m_req_valid two cycles after handshake", m_req_valid, 1'b1);
        wait_req(2'd0);
        send_req(2'd1, 1'b1, 2'd1, 1'b0);
        wait_req(2'd1);
    endtask

    task automatic route_responses();
        txn_id_u           tid;
        logic [31:0]       r;
        logic [DATA_W-1:0] data;
        logic              src;
        for (int i = 0; i < 2; i++)
        begin
            src  = (i == 0);
            r    = $random(seed);
            data = $random(seed);
            tid.view.src    = src;
            tid.view.sub_id = r[SUB_W-1:0];
            m_rsp_valid  = 1'b1;
            m_rsp_id     = tid.raw;
            m_rsp_rdata  = data;
            s0_rsp_ready = !src;
            s1_rsp_ready = src;
            #1;
            if (src)
            begin
                check_bits("s1_rsp_valid", s1_rsp_valid, 1'b1);
                check_bits("s0_rsp_valid", s0_rsp_valid, 1'b0);
                check_rsp("s1_rsp", s1_rsp_id, s1_rsp_rdata, tid.view.sub_id, data);
            end
            else
            begin
                check_bits("s0_rsp_valid", s0_rsp_valid, 1'b1);
                check_bits("s1_rsp_valid", s1_rsp_valid, 1'b0);
                check_rsp("s0_rsp", s0_rsp_id, s0_rsp_rdata, tid.view.sub_id, data);
            end
            check_bits("m_rsp_ready with addressed port ready", m_rsp_ready, 1'b1);
            // Only the addressed port drives m_rsp_ready
            @(negedge aclk);
            s0_rsp_ready = src;
            s1_rsp_ready = !src;
            #1;
            check_bits("m_rsp_ready with addressed port stalled", m_rsp_ready, 1'b0);
            @(negedge aclk);
        end
        m_rsp_valid  = 1'b0;
        s0_rsp_ready = 1'b1;
        s1_rsp_ready = 1'b1;
    endtask

    task automatic order_by_priority();
        m_req_ready = 1'b0;
        send_req(2'd0, 1'b0, 2'd1, 1'b1);
        send_req(2'd1, 1'b1, 2'd2, 1'b0);
        send_req(2'd2, 1'b0, 2'd3, 1'b1);
        // Queue 3 gets priority 0, queue 2 gets 1 and queue 1 gets 2
        write_cfg(4'd1, 32'h0000_0123);
        m_req_ready = 1'b1;
        wait_req(2'd0);
        wait_req(2'd2);
        wait_req(2'd1);
    endtask

    task automatic order_by_deadline();
        write_cfg(4'd0, 32'd1);
        write_cfg(4'd4, 32'd200);
        write_cfg(4'd3, 32'd20);
        m_req_ready = 1'b0;
        send_req(2'd0, 1'b0, 2'd0, 1'b1);
        send_req(2'd1, 1'b1, 2'd2, 1'b0);
        repeat (30) @(negedge aclk);
        send_req(2'd2, 1'b0, 2'd1, 1'b1);
        @(negedge aclk);
        m_req_ready = 1'b1;
        wait_req(2'd0);
        wait_req(2'd2);
        wait_req(2'd1);
    endtask

    task automatic raise_kill_alarm();
        write_cfg(4'd6, 32'({3'd2, 3'd4, 3'd4, 3'd4}));
        m_req_ready = 1'b0;
        // Filler takes the serializer so queue 3 keeps both requests
        send_req(2'd0, 1'b0, 2'd0, 1'b0);
        send_req(2'd1, 1'b1, 2'd3, 1'b1);
        send_req(2'd2, 1'b0, 2'd3, 1'b0);
        @(negedge aclk);
        expect_kill(4'b1000);
        m_req_ready = 1'b1;
        wait_req(2'd0);
        wait_req(2'd1);
        wait_req(2'd2);
        expect_kill(4'b0000);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence and watchdog
    initial
    begin
        seed         = 32'he93e;
        errors       = 0;
        s0_valid     = 1'b0;
        s0_addr      = '0;
        s0_id        = '0;
        s0_write     = 1'b0;
        s0_wdata     = '0;
        s1_valid     = 1'b0;
        s1_addr      = '0;
        s1_id        = '0;
        s1_write     = 1'b0;
        s1_wdata     = '0;
        m_req_ready  = 1'b1;
        m_rsp_valid  = 1'b0;
        m_rsp_id     = '0;
        m_rsp_rdata  = '0;
        s0_rsp_ready = 1'b1;
        s1_rsp_ready = 1'b1;
        cfg_write    = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        wait (rst_n === 1'b1);
        @(negedge aclk);
        reset_state();
        tag_requests();
        route_responses();
        order_by_priority();
        order_by_deadline();
        raise_kill_alarm();
        $display("Tests finished with %0d errors", errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule
